// ==== list.f ====
+incdir+source
source/bicubic_pkg.sv
source/frac_divider.sv
source/frac_table.sv
source/cubic_engine.sv
source/separable_interp.sv
source/bicubic_ctrl.sv
source/bicubic_top.sv
tb/bicubic_asserts.sv
tb/tb_bicubic.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bicubic
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_STR  ?= TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_bicubic.sv ====
`include "bicubic_params.svh"

module tb_bicubic;
    import bicubic_pkg::*;

    localparam int HOLD_CYCLES = 20;

    logic               CLK = 1'b0;
    logic               RST;
    scale_cfg_t         cfg;
    logic [`PIX_W-1:0]  rom_data;
    logic               rom_en;
    logic [`ROM_AW-1:0] rom_addr;
    logic               res_we;
    res_wr_t            res;
    logic               done;

    logic [`PIX_W-1:0]  image [`IMG_W * `IMG_H];
    integer             seed;
    string              test_name;
    bit                 identity;
    bit                 timed_out;
    int                 write_cnt;
    int                 test_errors;
    int                 failed_tests;
    int                 test_cnt;

    always #5 CLK = ~CLK;

    bicubic_top dut_i (
        .CLK        (CLK),
        .RST        (RST),
        .cfg_i      (cfg),
        .rom_data_i (rom_data),
        .rom_en_o   (rom_en),
        .rom_addr_o (rom_addr),
        .res_we_o   (res_we),
        .res_o      (res),
        .done_o     (done)
    );

    bind bicubic_top bicubic_asserts asserts_i (
        .CLK        (CLK),
        .RST        (RST),
        .cfg_i      (cfg_i),
        .rom_en_i   (rom_en_o),
        .rom_addr_i (rom_addr_o),
        .res_we_i   (res_we_o),
        .res_i      (res_o),
        .done_i     (done_o)
    );

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Q0.8 fraction, rounded to nearest
    function automatic int frac_of(input int r, input int t);
        return (r * 256 + (t - 1) / 2) / (t - 1);
    endfunction

    function automatic int cubic_ref(input cubic_req_t req);
        int p0;
        int p1;
        int p2;
        int p3;
        int t;
        int x2;
        int x3;
        int acc;
        int res_v;
        p0 = req.taps[0];
        p1 = req.taps[1];
        p2 = req.taps[2];
        p3 = req.taps[3];
        t  = req.t;
        x2 = (t * t + 128) / 256;
        x3 = (x2 * t + 128) / 256;
        acc = 512 * p1 + t * (p2 - p0) + x2 * (2 * p0 - 5 * p1 + 4 * p2 - p3)
              + x3 * (-p0 + 3 * p1 - 3 * p2 + p3);
        res_v = (acc + 256) >>> 9;  // floor, also for negative sums
        if (res_v < 0) res_v = 0;
        if (res_v > 255) res_v = 255;
        return res_v;
    endfunction

    // target pixel (i, j) mapped onto the source window
    function automatic pix_job_t job_for(input int i, input int j);
        pix_job_t job;
        int sw;
        int sh;
        int tw;
        int th;
        sw = int'(cfg.sw);
        sh = int'(cfg.sh);
        tw = int'(cfg.tw);
        th = int'(cfg.th);
        job.src_col = `COORD_W'(int'(cfg.h0) + j * (sw - 1) / (tw - 1));
        job.src_row = `COORD_W'(int'(cfg.v0) + i * (sh - 1) / (th - 1));
        job.frac_h  = `FRAC_W'(frac_of(j * (sw - 1) % (tw - 1), tw));
        job.frac_v  = `FRAC_W'(frac_of(i * (sh - 1) % (th - 1), th));
        job.tgt_row = `TGT_DIM_W'(i);
        job.tgt_col = `TGT_DIM_W'(j);
        return job;
    endfunction

    function automatic int expected_pixel(input pix_job_t job);
        cubic_req_t             req;
        logic [3:0][`PIX_W-1:0] col;
        int                     addr;
        for (int a = 0; a < 4; a++) begin
            for (int b = 0; b < 4; b++) begin
                addr = (int'(job.src_row) + a - 1) * `IMG_W + int'(job.src_col) + b - 1;
                req.taps[b] = image[addr];
            end
            req.t  = job.frac_h;
            col[a] = `PIX_W'(cubic_ref(req));  // horizontal pass per tap row
        end
        req.taps = col;
        req.t    = job.frac_v;
        return cubic_ref(req);
    endfunction

    function automatic scale_cfg_t random_cfg();
        scale_cfg_t c;
        c.sw = `SRC_DIM_W'(2 + rand_below(30));
        c.sh = `SRC_DIM_W'(2 + rand_below(30));
        c.tw = `TGT_DIM_W'(2 + rand_below(62));
        c.th = `TGT_DIM_W'(2 + rand_below(62));
        c.h0 = `COORD_W'(1 + rand_below(98 - int'(c.sw)));  // keeps h0 + sw + 1 <= 99
        c.v0 = `COORD_W'(1 + rand_below(98 - int'(c.sh)));
        return c;
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected !== actual) begin
            $display("Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    always @(posedge CLK) begin
        if (rom_en) begin
            rom_data <= image[rom_addr];
        end
    end

    // result port monitor
    always @(posedge CLK) begin
        int exp_i;
        int exp_j;
        if (!RST && res_we) begin
            exp_i = write_cnt % int'(cfg.th);
            exp_j = write_cnt / int'(cfg.th);
            if (done) begin
                $display("Error: %s wrote a pixel while done_o was high", test_name);
                test_errors++;
            end
            if (write_cnt >= int'(cfg.tw) * int'(cfg.th)) begin
                $display("Error: %s wrote more pixels than the target holds", test_name);
                test_errors++;
            end else begin
                check_value("row", exp_i, int'(res.row));
                check_value("col", exp_j, int'(res.col));
                check_value("pixel", expected_pixel(job_for(exp_i, exp_j)), int'(res.data));
                if (identity) begin
                    check_value("source copy",
                                int'(image[(int'(cfg.v0) + exp_i) * `IMG_W
                                           + int'(cfg.h0) + exp_j]),
                                int'(res.data));
                end
            end
            write_cnt++;
        end
    end

    // tap reads must stay next to the window
    always @(posedge CLK) begin
        int row;
        int col;
        if (!RST && rom_en) begin
            row = int'(rom_addr) / `IMG_W;
            col = int'(rom_addr) % `IMG_W;
            if (row < int'(cfg.v0) - 1 || row > int'(cfg.v0) + int'(cfg.sh) + 1
                || col < int'(cfg.h0) - 1 || col > int'(cfg.h0) + int'(cfg.sw) + 1) begin
                $display("Error: %s read the image at row %0d col %0d, outside the window",
                         test_name, row, col);
                test_errors++;
            end
        end
    end

    task automatic run_test(input string name, input scale_cfg_t c, input bit ident);
        int limit;
        int cycles;
        test_name   = name;
        identity    = ident;
        write_cnt   = 0;
        test_errors = 0;
        limit       = 5000 + int'(c.tw) * int'(c.th) * 60;
        @(posedge CLK);
        RST <= 1'b1;
        cfg <= c;
        repeat (10) @(posedge CLK);
        RST <= 1'b0;
        @(posedge CLK);
        check_value("done_o after reset", 0, int'(done));
        check_value("rom_en_o after reset", 0, int'(rom_en));
        check_value("res_we_o after reset", 0, int'(res_we));
        cycles = 0;
        while (!done && cycles < limit) begin
            @(posedge CLK);
            cycles++;
        end
        if (!done) begin
            $display("%s: no done_o after %0d cycles, the run timed out", name, cycles);
            timed_out = 1'b1;
            test_errors++;
        end else begin
            check_value("writes before done_o", int'(c.tw) * int'(c.th), write_cnt);
            repeat (HOLD_CYCLES) begin
                @(posedge CLK);
                check_value("done_o held", 1, int'(done));
            end
            check_value("write count", int'(c.tw) * int'(c.th), write_cnt);
        end
        test_cnt++;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("%s: %0d writes, %0d errors", name, write_cnt, test_errors);
    endtask

    initial begin
        scale_cfg_t nominal_cfg;
        scale_cfg_t identity_cfg;
        RST          = 1'b1;
        cfg          = '0;
        rom_data     = '0;
        seed         = 32'hcadb_14a3;
        timed_out    = 1'b0;
        failed_tests = 0;
        test_cnt     = 0;
        for (int a = 0; a < `IMG_W * `IMG_H; a++) begin
            image[a] = `PIX_W'($random(seed));
        end
        nominal_cfg  = '{v0: 7'd18, h0: 7'd81, sw: 5'd17, sh: 5'd15, tw: 6'd22, th: 6'd28};
        identity_cfg = '{v0: 7'd5, h0: 7'd40, sw: 5'd20, sh: 5'd12, tw: 6'd20, th: 6'd12};

        run_test("nominal", nominal_cfg, 1'b0);
        if (!timed_out) begin
            run_test("identity", identity_cfg, 1'b1);
        end
        if (!timed_out) begin
            run_test("random", random_cfg(), 1'b0);
        end

        $display("tests run %0d, tests failed %0d", test_cnt, failed_tests);
        if (failed_tests == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== tb/bicubic_asserts.sv ====
`include "bicubic_params.svh"

module bicubic_asserts (
    input logic                    CLK,
    input logic                    RST,
    input bicubic_pkg::scale_cfg_t cfg_i,
    input logic                    rom_en_i,
    input logic [`ROM_AW-1:0]      rom_addr_i,
    input logic                    res_we_i,
    input bicubic_pkg::res_wr_t    res_i,
    input logic                    done_i
);
    import bicubic_pkg::*;

    // done is sticky until the next reset
    a_done_held: assert property (@(posedge CLK) disable iff (RST)
        done_i |=> done_i)
        else $error("done_o fell while reset was low");

    a_no_write_after_done: assert property (@(posedge CLK) disable iff (RST)
        !(res_we_i && done_i))
        else $error("res_we_o high while done_o high");

    a_res_in_target: assert property (@(posedge CLK) disable iff (RST)
        res_we_i |-> (res_i.row < cfg_i.th) && (res_i.col < cfg_i.tw))
        else $error("result written outside the target image");

    a_rom_in_image: assert property (@(posedge CLK) disable iff (RST)
        rom_en_i |-> rom_addr_i < `ROM_AW'(`IMG_W * `IMG_H))
        else $error("image read beyond the last pixel");

endmodule

// ==== source/bicubic_top.sv ====
`include "bicubic_params.svh"

module bicubic_top (
    input  logic                    CLK,
    input  logic                    RST,
    input  bicubic_pkg::scale_cfg_t cfg_i,
    input  logic [`PIX_W-1:0]       rom_data_i,
    output logic                    rom_en_o,
    output logic [`ROM_AW-1:0]      rom_addr_o,
    output logic                    res_we_o,
    output bicubic_pkg::res_wr_t    res_o,
    output logic                    done_o
);
    import bicubic_pkg::*;

    logic                  div_start;
    logic [`TGT_DIM_W-1:0] div_rem;
    logic [`TGT_DIM_W-1:0] div_divisor;
    logic                  div_done;
    logic [`FRAC_W-1:0]    div_frac;
    frac_wr_t              tbl_wr;
    logic [`TGT_DIM_W-1:0] tbl_rd_h;
    logic [`TGT_DIM_W-1:0] tbl_rd_v;
    logic [`FRAC_W-1:0]    tbl_h;
    logic [`FRAC_W-1:0]    tbl_v;
    logic                  job_start;
    pix_job_t              job;
    logic                  job_done;
    logic                  req_valid;
    cubic_req_t            req;
    logic                  rsp_valid;
    logic [`PIX_W-1:0]     rsp;

    bicubic_ctrl ctrl_i (
        .CLK           (CLK),
        .RST           (RST),
        .cfg_i         (cfg_i),
        .div_start_o   (div_start),
        .div_rem_o     (div_rem),
        .div_divisor_o (div_divisor),
        .div_done_i    (div_done),
        .div_frac_i    (div_frac),
        .tbl_wr_o      (tbl_wr),
        .tbl_rd_h_o    (tbl_rd_h),
        .tbl_rd_v_o    (tbl_rd_v),
        .tbl_h_i       (tbl_h),
        .tbl_v_i       (tbl_v),
        .job_start_o   (job_start),
        .job_o         (job),
        .job_done_i    (job_done),
        .done_o        (done_o)
    );

    frac_divider div_i (
        .CLK       (CLK),
        .RST       (RST),
        .start_i   (div_start),
        .rem_i     (div_rem),
        .divisor_i (div_divisor),
        .done_o    (div_done),
        .frac_o    (div_frac)
    );

    frac_table tbl_i (
        .CLK      (CLK),
        .wr_i     (tbl_wr),
        .rd_h_i   (tbl_rd_h),
        .rd_v_i   (tbl_rd_v),
        .frac_h_o (tbl_h),
        .frac_v_o (tbl_v)
    );

    separable_interp interp_i (
        .CLK         (CLK),
        .RST         (RST),
        .job_start_i (job_start),
        .job_i       (job),
        .rom_en_o    (rom_en_o),
        .rom_addr_o  (rom_addr_o),
        .rom_data_i  (rom_data_i),
        .req_valid_o (req_valid),
        .req_o       (req),
        .rsp_valid_i (rsp_valid),
        .rsp_i       (rsp),
        .res_we_o    (res_we_o),
        .res_o       (res_o),
        .job_done_o  (job_done)
    );

    cubic_engine engine_i (
        .CLK         (CLK),
        .RST         (RST),
        .req_valid_i (req_valid),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

endmodule

// ==== source/bicubic_ctrl.sv ====
`include "bicubic_params.svh"

module bicubic_ctrl (
    input  logic                    CLK,
    input  logic                    RST,
    input  bicubic_pkg::scale_cfg_t cfg_i,
    output logic                    div_start_o,
    output logic [`TGT_DIM_W-1:0]   div_rem_o,
    output logic [`TGT_DIM_W-1:0]   div_divisor_o,
    input  logic                    div_done_i,
    input  logic [`FRAC_W-1:0]      div_frac_i,
    output bicubic_pkg::frac_wr_t   tbl_wr_o,
    output logic [`TGT_DIM_W-1:0]   tbl_rd_h_o,
    output logic [`TGT_DIM_W-1:0]   tbl_rd_v_o,
    input  logic [`FRAC_W-1:0]      tbl_h_i,
    input  logic [`FRAC_W-1:0]      tbl_v_i,
    output logic                    job_start_o,
    output bicubic_pkg::pix_job_t   job_o,
    input  logic                    job_done_i,
    output logic                    done_o
);
    import bicubic_pkg::*;

    typedef enum logic [2:0] {
        S_DIV_GO,
        S_DIV_WAIT,
        S_NORM,
        S_LOOKUP,
        S_JOB,
        S_JOB_WAIT,
        S_DONE
    } state_t;

    state_t                state;
    frac_bank_t            init_bank;
    logic [`TGT_DIM_W-1:0] init_idx;
    logic [`TGT_DIM_W-1:0] tgt_row;
    logic [`TGT_DIM_W-1:0] tgt_col;
    logic [`COORD_W-1:0]   quot_h;
    logic [`COORD_W-1:0]   quot_v;
    logic [`COORD_W-1:0]   rem_h;
    logic [`COORD_W-1:0]   rem_v;
    logic [`TGT_DIM_W-1:0] last_h;   // TW-1
    logic [`TGT_DIM_W-1:0] last_v;   // TH-1
    logic                  wr_now;

    assign last_h = cfg_i.tw - 1'b1;
    assign last_v = cfg_i.th - 1'b1;

    assign div_start_o   = (state == S_DIV_GO);
    assign div_rem_o     = init_idx;
    assign div_divisor_o = (init_bank == BANK_H) ? last_h : last_v;

    // idle cycles write the top entry, no remainder ever reaches it
    assign wr_now   = (state == S_DIV_WAIT) && div_done_i;
    assign tbl_wr_o = '{bank:  init_bank,
                        index: wr_now ? init_idx : `TGT_DIM_W'(`TBL_DEPTH - 1),
                        value: div_frac_i};

    assign tbl_rd_h_o = rem_h[`TGT_DIM_W-1:0];
    assign tbl_rd_v_o = rem_v[`TGT_DIM_W-1:0];

    assign job_start_o = (state == S_JOB);
    assign job_o = '{src_row: cfg_i.v0 + quot_v,
                     src_col: cfg_i.h0 + quot_h,
                     frac_h:  tbl_h_i,
                     frac_v:  tbl_v_i,
                     tgt_row: tgt_row,
                     tgt_col: tgt_col};

    assign done_o = (state == S_DONE);

    always_ff @(posedge CLK) begin
        if (RST) begin
            state     <= S_DIV_GO;
            init_bank <= BANK_H;
            init_idx  <= '0;
            tgt_row   <= '0;
            tgt_col   <= '0;
            quot_h    <= '0;
            quot_v    <= '0;
            rem_h     <= '0;
            rem_v     <= '0;
        end else begin
            case (state)
                S_DIV_GO: state <= S_DIV_WAIT;
                S_DIV_WAIT: begin
                    if (div_done_i) begin
                        if (init_idx == div_divisor_o - 1'b1) begin
                            init_idx <= '0;
                            if (init_bank == BANK_H) begin
                                init_bank <= BANK_V;
                                state     <= S_DIV_GO;
                            end else begin
                                state <= S_NORM;  // both banks filled
                            end
                        end else begin
                            init_idx <= init_idx + 1'b1;
                            state    <= S_DIV_GO;
                        end
                    end
                end
                // one carry per cycle, so downscaling also settles
                S_NORM: begin
                    if (rem_h >= last_h) begin
                        rem_h  <= rem_h - last_h;
                        quot_h <= quot_h + 1'b1;
                    end else if (rem_v >= last_v) begin
                        rem_v  <= rem_v - last_v;
                        quot_v <= quot_v + 1'b1;
                    end else begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: state <= S_JOB;     // table read in flight
                S_JOB:    state <= S_JOB_WAIT;
                S_JOB_WAIT: begin
                    if (job_done_i) begin
                        if (tgt_row == last_v) begin
                            tgt_row <= '0;
                            quot_v  <= '0;
                            rem_v   <= '0;
                            tgt_col <= tgt_col + 1'b1;
                            rem_h   <= rem_h + cfg_i.sw - 1'b1;
                            state   <= (tgt_col == last_h) ? S_DONE : S_NORM;
                        end else begin
                            tgt_row <= tgt_row + 1'b1;
                            rem_v   <= rem_v + cfg_i.sh - 1'b1;
                            state   <= S_NORM;
                        end
                    end
                end
                default: state <= S_DONE;  // held until reset
            endcase
        end
    end

endmodule

// ==== source/separable_interp.sv ====
`include "bicubic_params.svh"

module separable_interp (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    job_start_i,
    input  bicubic_pkg::pix_job_t   job_i,
    output logic                    rom_en_o,
    output logic [`ROM_AW-1:0]      rom_addr_o,
    input  logic [`PIX_W-1:0]       rom_data_i,
    output logic                    req_valid_o,
    output bicubic_pkg::cubic_req_t req_o,
    input  logic                    rsp_valid_i,
    input  logic [`PIX_W-1:0]       rsp_i,
    output logic                    res_we_o,
    output bicubic_pkg::res_wr_t    res_o,
    output logic                    job_done_o
);
    import bicubic_pkg::*;

    pix_job_t               job_q;
    logic [3:0]             rd_idx;     // {tap row, tap col}
    logic [1:0]             data_idx;
    logic                   data_vld;
    logic [`COORD_W-1:0]    tap_row;
    logic [`COORD_W-1:0]    tap_col;
    logic [2:0][`PIX_W-1:0] row_buf;    // first three taps of a row
    logic [2:0][`PIX_W-1:0] col_buf;    // first three horizontal results
    logic [1:0]             h_cnt;
    logic                   v_phase;
    logic                   row_last;
    logic                   h_last;
    logic                   v_rsp;

    // 4x4 block spans p1 - 1 .. p1 + 2 in both directions
    assign tap_row    = job_q.src_row + rd_idx[3:2] - 1'b1;
    assign tap_col    = job_q.src_col + rd_idx[1:0] - 1'b1;
    assign rom_addr_o = `ROM_AW'(tap_row) * `ROM_AW'(`IMG_W) + `ROM_AW'(tap_col);

    assign row_last = data_vld && (data_idx == 2'd3);
    assign h_last   = rsp_valid_i && !v_phase && (h_cnt == 2'd3);
    assign v_rsp    = rsp_valid_i && v_phase;

    always_ff @(posedge CLK) begin
        if (RST) begin
            rom_en_o    <= 1'b0;
            rd_idx      <= '0;
            data_vld    <= 1'b0;
            req_valid_o <= 1'b0;
            res_we_o    <= 1'b0;
            job_done_o  <= 1'b0;
            h_cnt       <= '0;
            v_phase     <= 1'b0;
        end else begin
            if (job_start_i) begin
                rom_en_o <= 1'b1;
                rd_idx   <= '0;
            end else if (rom_en_o) begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == 4'd15) begin
                    rom_en_o <= 1'b0;
                end
            end
            data_vld    <= rom_en_o;  // ROM answers a cycle later
            req_valid_o <= row_last || h_last;
            res_we_o    <= v_rsp;
            job_done_o  <= v_rsp;
            if (rsp_valid_i) begin
                if (v_phase) begin
                    v_phase <= 1'b0;
                end else begin
                    h_cnt <= h_cnt + 1'b1;
                    if (h_cnt == 2'd3) begin
                        v_phase <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (job_start_i) begin
            job_q <= job_i;
        end
        data_idx <= rd_idx[1:0];
        if (data_vld) begin
            row_buf <= {rom_data_i, row_buf[2:1]};
        end
        if (rsp_valid_i && !v_phase) begin
            col_buf <= {rsp_i, col_buf[2:1]};
        end
        // horizontal and vertical requests never fall in the same cycle
        if (row_last) begin
            req_o <= '{taps: {rom_data_i, row_buf}, t: job_q.frac_h};
        end else if (h_last) begin
            req_o <= '{taps: {rsp_i, col_buf}, t: job_q.frac_v};
        end
        if (v_rsp) begin
            res_o <= '{row:  `COORD_W'(job_q.tgt_row),
                       col:  `COORD_W'(job_q.tgt_col),
                       data: rsp_i};
        end
    end

endmodule

// ==== source/cubic_engine.sv ====
`include "bicubic_params.svh"

module cubic_engine (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    req_valid_i,
    input  bicubic_pkg::cubic_req_t req_i,
    output logic                    rsp_valid_o,
    output logic [`PIX_W-1:0]       rsp_o
);
    localparam int CW = `PIX_W + 4;  // coefficient sums up to about +-1530

    logic                       vld1;
    logic                       vld2;
    logic signed [CW-1:0]       p [4];
    logic [2*`FRAC_W-1:0]       sq;
    logic [2*`FRAC_W-1:0]       cube;

    // stage 1
    logic [`FRAC_W-1:0]         s1_t;
    logic [`FRAC_W-1:0]         s1_x2;
    logic [`PIX_W-1:0]          s1_p1;
    logic signed [CW-1:0]       s1_c1;  // p2 - p0
    logic signed [CW-1:0]       s1_c2;  // 2p0 - 5p1 + 4p2 - p3
    logic signed [CW-1:0]       s1_c3;  // -p0 + 3p1 - 3p2 + p3

    // stage 2
    logic signed [`ACC_W-1:0]   s2_m0;
    logic signed [`ACC_W-1:0]   s2_m1;
    logic signed [`ACC_W-1:0]   s2_m2;
    logic signed [`ACC_W-1:0]   s2_m3;

    logic signed [`ACC_W-1:0]   acc;
    logic signed [`ACC_W-1:0]   scaled;

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            p[k] = $signed({4'b0000, req_i.taps[k]});
        end
        sq     = req_i.t * req_i.t + 16'd128;
        cube   = s1_x2 * s1_t + 16'd128;
        acc    = s2_m0 + s2_m1 + s2_m2 + s2_m3 + 24'sd256;
        scaled = acc >>> 9;  // floor division by 512
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            vld1        <= 1'b0;
            vld2        <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            vld1        <= req_valid_i;
            vld2        <= vld1;
            rsp_valid_o <= vld2;
        end
    end

    always_ff @(posedge CLK) begin
        s1_t  <= req_i.t;
        s1_x2 <= sq[2*`FRAC_W-1:`FRAC_W];
        s1_p1 <= req_i.taps[1];
        s1_c1 <= p[2] - p[0];
        s1_c2 <= 2 * p[0] - 5 * p[1] + 4 * p[2] - p[3];
        s1_c3 <= 3 * p[1] - 3 * p[2] + p[3] - p[0];

        s2_m0 <= {{(`ACC_W - `PIX_W - 9){1'b0}}, s1_p1, 9'd0};
        s2_m1 <= $signed({1'b0, s1_t}) * s1_c1;
        s2_m2 <= $signed({1'b0, s1_x2}) * s1_c2;
        s2_m3 <= $signed({1'b0, cube[2*`FRAC_W-1:`FRAC_W]}) * s1_c3;  // x3 * c3

        if (scaled < 0) begin
            rsp_o <= '0;
        end else if (scaled > 255) begin
            rsp_o <= '1;
        end else begin
            rsp_o <= scaled[`PIX_W-1:0];
        end
    end

endmodule

// ==== source/frac_table.sv ====
`include "bicubic_params.svh"

module frac_table (
    input  logic                  CLK,
    input  bicubic_pkg::frac_wr_t wr_i,
    input  logic [`TGT_DIM_W-1:0] rd_h_i,
    input  logic [`TGT_DIM_W-1:0] rd_v_i,
    output logic [`FRAC_W-1:0]    frac_h_o,
    output logic [`FRAC_W-1:0]    frac_v_o
);
    import bicubic_pkg::*;

    logic [`FRAC_W-1:0] bank_h [`TBL_DEPTH];
    logic [`FRAC_W-1:0] bank_v [`TBL_DEPTH];

    always_ff @(posedge CLK) begin
        if (wr_i.bank == BANK_H) begin
            bank_h[wr_i.index] <= wr_i.value;
        end else begin
            bank_v[wr_i.index] <= wr_i.value;
        end
        frac_h_o <= bank_h[rd_h_i];
        frac_v_o <= bank_v[rd_v_i];
    end

endmodule

// ==== source/frac_divider.sv ====
`include "bicubic_params.svh"

module frac_divider (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  start_i,
    input  logic [`TGT_DIM_W-1:0] rem_i,
    input  logic [`TGT_DIM_W-1:0] divisor_i,
    output logic                  done_o,
    output logic [`FRAC_W-1:0]    frac_o
);
    localparam int DIV_W = 2 * `FRAC_W;

    logic [4:0]            cnt;
    logic [DIV_W-1:0]      quo;     // dividend shifting out, quotient in
    logic [`TGT_DIM_W-1:0] part;    // partial remainder
    logic [`TGT_DIM_W-1:0] dvs;
    logic [`TGT_DIM_W:0]   shifted;
    logic [`TGT_DIM_W:0]   diff;

    assign shifted = {part, quo[DIV_W-1]};
    assign diff    = shifted - {1'b0, dvs};
    assign frac_o  = quo[`FRAC_W-1:0];  // rem < divisor keeps the upper bits zero

    always_ff @(posedge CLK) begin
        if (RST) begin
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= (cnt == 5'd1);
            if (start_i) begin
                cnt <= 5'(DIV_W);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start_i) begin
            // rem*256 + divisor/2 rounds to nearest
            quo  <= {rem_i, {`FRAC_W{1'b0}}} + DIV_W'(divisor_i >> 1);
            part <= '0;
            dvs  <= divisor_i;
        end else if (cnt != '0) begin
            if (shifted >= {1'b0, dvs}) begin
                part <= diff[`TGT_DIM_W-1:0];
                quo  <= {quo[DIV_W-2:0], 1'b1};
            end else begin
                part <= shifted[`TGT_DIM_W-1:0];
                quo  <= {quo[DIV_W-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== source/bicubic_pkg.sv ====
`include "bicubic_params.svh"

package bicubic_pkg;

    typedef struct packed {
        logic [`COORD_W-1:0]   v0;
        logic [`COORD_W-1:0]   h0;
        logic [`SRC_DIM_W-1:0] sw;
        logic [`SRC_DIM_W-1:0] sh;
        logic [`TGT_DIM_W-1:0] tw;
        logic [`TGT_DIM_W-1:0] th;
    } scale_cfg_t;

    typedef enum logic {
        BANK_H,
        BANK_V
    } frac_bank_t;

    typedef struct packed {
        frac_bank_t            bank;
        logic [`TGT_DIM_W-1:0] index;
        logic [`FRAC_W-1:0]    value;
    } frac_wr_t;

    // src_row/src_col locate tap p1 in absolute image coordinates
    typedef struct packed {
        logic [`COORD_W-1:0]   src_row;
        logic [`COORD_W-1:0]   src_col;
        logic [`FRAC_W-1:0]    frac_h;
        logic [`FRAC_W-1:0]    frac_v;
        logic [`TGT_DIM_W-1:0] tgt_row;
        logic [`TGT_DIM_W-1:0] tgt_col;
    } pix_job_t;

    typedef struct packed {
        logic [3:0][`PIX_W-1:0] taps;  // taps[k] is p_k
        logic [`FRAC_W-1:0]     t;
    } cubic_req_t;

    typedef struct packed {
        logic [`COORD_W-1:0] row;
        logic [`COORD_W-1:0] col;
        logic [`PIX_W-1:0]   data;
    } res_wr_t;

endpackage

// ==== source/bicubic_params.svh ====
`ifndef BICUBIC_PARAMS_SVH
`define BICUBIC_PARAMS_SVH

// source image
`define IMG_W      100
`define IMG_H      100
`define PIX_W      8
`define ROM_AW     14

// Q0.8 fractions
`define FRAC_W     8
`define TBL_DEPTH  64

`define COORD_W    7
`define SRC_DIM_W  5
`define TGT_DIM_W  6

// cubic engine
`define ACC_W      24
`define CUBIC_LAT  3

`endif
